//--- Makefile
VERILATOR ?= verilator
TOP       ?= pipeControlTb
FILELIST  ?= pipeControl.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- hazardPkg.sv
package hazardPkg;

    localparam int FWD_SEL_BITS = 3;

    //////////////////////////////
    // Forwarding select codes
    //////////////////////////////

    // Upper bit picks the second write port
    typedef enum logic [FWD_SEL_BITS-1:0] {
        FWD_NONE = 3'b000,
        FWD_W    = 3'b001,
        FWD_M    = 3'b010,
        FWD_W2   = 3'b101,
        FWD_M2   = 3'b110
    } fwdSel_t;

    //////////////////////////////
    // Hazard control outputs
    //////////////////////////////

    typedef struct packed {
        fwdSel_t forwardAE;
        fwdSel_t forwardBE;
        logic    forwardM;
        logic    stallF;
        logic    stallD;
        logic    flushD;
        logic    flushE;
        logic    mcycleHazard;
    } hazardCtrl_t;

endpackage

//--- hazardUnit.sv
module hazardUnit (
    input  pipePkg::decodeInstr_t  decodeIn,
    input  pipePkg::stageRec_t     stageE,
    input  pipePkg::stageRec_t     stageM,
    input  pipePkg::stageRec_t     stageW,
    input  pipePkg::port2Rec_t     port2M,
    input  pipePkg::port2Rec_t     port2W,
    input  logic                   mcBusy,
    input  logic                   mcDone,
    input  pipePkg::regAddr_t      mcDest,
    output hazardPkg::hazardCtrl_t ctrl
);
    import pipePkg::*;
    import hazardPkg::*;

    logic writeM;
    logic writeW;
    logic mStartE;
    logic branchE;
    logic ldrStall;
    logic busyHit;
    logic startHit;
    logic mcOverlap;
    logic mcycleHazard;
    logic stall;

    // Highest priority pending write wins
    function automatic fwdSel_t pickFwd(
        input logic      srcValid,
        input regAddr_t  src,
        input port2Rec_t p2M,
        input port2Rec_t p2W,
        input logic      wrM,
        input regAddr_t  destM,
        input logic      wrW,
        input regAddr_t  destW
    );
        fwdSel_t sel;
        sel = FWD_NONE;
        if (srcValid) begin
            if (p2M.regWrite2 && src == p2M.wa5) begin
                sel = FWD_M2;
            end else if (p2W.regWrite2 && src == p2W.wa5) begin
                sel = FWD_W2;
            end else if (wrM && src == destM) begin
                sel = FWD_M;
            end else if (wrW && src == destW) begin
                sel = FWD_W;
            end
        end
        return sel;
    endfunction

    assign writeM  = stageM.valid && stageM.regWrite;
    assign writeW  = stageW.valid && stageW.regWrite;
    assign mStartE = stageE.valid && stageE.mStart;
    assign branchE = stageE.valid && stageE.branchTaken;

    //////////////////////////////
    // Stall sources
    //////////////////////////////

    // Load in Execute feeding Decode
    assign ldrStall = decodeIn.valid && stageE.valid && stageE.regWrite
        && stageE.memtoReg
        && (decodeIn.ra1 == stageE.wa3 || decodeIn.ra2 == stageE.wa3);

    // Decode touches the busy op's destination
    assign busyHit = mcBusy && decodeIn.valid
        && (decodeIn.ra1 == mcDest || decodeIn.ra2 == mcDest
            || decodeIn.wa3 == mcDest);

    // Same check while the op is still in Execute
    assign startHit = mStartE && decodeIn.valid
        && (decodeIn.ra1 == stageE.wa3 || decodeIn.ra2 == stageE.wa3
            || decodeIn.wa3 == stageE.wa3);

    // Only one multi-cycle op in flight
    assign mcOverlap = decodeIn.valid && decodeIn.isMcycle && (mcBusy || mStartE);

    assign mcycleHazard = busyHit || startHit || mcOverlap;
    // Done cycle holds Decode while port 2 takes the write
    assign stall = ldrStall || mcDone || mcycleHazard;

    //////////////////////////////
    // Output record
    //////////////////////////////

    always_comb begin
        ctrl.forwardAE = pickFwd(stageE.valid, stageE.ra1, port2M, port2W,
                                 writeM, stageM.wa3, writeW, stageW.wa3);
        ctrl.forwardBE = pickFwd(stageE.valid, stageE.ra2, port2M, port2W,
                                 writeM, stageM.wa3, writeW, stageW.wa3);
        ctrl.forwardM = stageM.valid && stageM.memWrite && writeW
            && stageW.memtoReg && (stageM.ra2 == stageW.wa3);
        ctrl.stallF = stall;
        ctrl.stallD = stall;
        ctrl.flushD = branchE;
        ctrl.flushE = ldrStall || branchE;
        ctrl.mcycleHazard = mcycleHazard;
    end

endmodule

//--- mcycleSequencer.sv
module mcycleSequencer (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  pipePkg::regAddr_t startDest,
    output logic              mcBusy,
    output logic              mcDone,
    output pipePkg::regAddr_t mcDest
);
    import pipePkg::*;

    logic [MCYCLE_CNT_BITS-1:0] busyCnt;
    logic                       idle;
    logic                       lastBusy;

    // Nonzero count marks the busy window
    assign mcBusy   = (busyCnt != '0);
    assign idle     = !mcBusy && !mcDone;
    assign lastBusy = (busyCnt == MCYCLE_CNT_BITS'(1));

    //////////////////////////////
    // Latency counter
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busyCnt <= '0;
            mcDone  <= 1'b0;
        end else begin
            // Done follows the last busy cycle
            mcDone <= lastBusy;
            if (start && idle) begin
                busyCnt <= MCYCLE_CNT_BITS'(MCYCLE_LATENCY);
            end else if (mcBusy) begin
                busyCnt <= busyCnt - 1'b1;
            end
        end
    end

    // Destination of the op in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            mcDest <= '0;
        end else if (start && idle) begin
            mcDest <= startDest;
        end
    end

endmodule

//--- pipeControl.f
pipePkg.sv
hazardPkg.sv
stageTracker.sv
mcycleSequencer.sv
hazardUnit.sv
pipeControl.sv
pipeControl_assertions.sv
pipeControlTb.sv

//--- pipeControl.sv
module pipeControl (
    input  logic                   clk,
    input  logic                   rst,
    input  pipePkg::decodeInstr_t  decodeIn,
    output hazardPkg::hazardCtrl_t ctrl
);
    import pipePkg::*;

    stageRec_t stageE;
    stageRec_t stageM;
    stageRec_t stageW;
    port2Rec_t port2M;
    port2Rec_t port2W;
    logic      mcBusy;
    logic      mcDone;
    regAddr_t  mcDest;

    stageTracker stageTracker_i (
        .clk      (clk),
        .rst      (rst),
        .decodeIn (decodeIn),
        .stallD   (ctrl.stallD),
        .flushE   (ctrl.flushE),
        .mcDone   (mcDone),
        .mcDest   (mcDest),
        .stageE   (stageE),
        .stageM   (stageM),
        .stageW   (stageW),
        .port2M   (port2M),
        .port2W   (port2W)
    );

    // Op starts from its Execute record
    mcycleSequencer mcycleSequencer_i (
        .clk       (clk),
        .rst       (rst),
        .start     (stageE.mStart),
        .startDest (stageE.wa3),
        .mcBusy    (mcBusy),
        .mcDone    (mcDone),
        .mcDest    (mcDest)
    );

    hazardUnit hazardUnit_i (
        .decodeIn (decodeIn),
        .stageE   (stageE),
        .stageM   (stageM),
        .stageW   (stageW),
        .port2M   (port2M),
        .port2W   (port2W),
        .mcBusy   (mcBusy),
        .mcDone   (mcDone),
        .mcDest   (mcDest),
        .ctrl     (ctrl)
    );

endmodule

//--- pipeControlTb.sv
module pipeControlTb;
    import pipePkg::*;
    import hazardPkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 8;
    localparam int NUM_CYCLES    = 3000;
    localparam int WATCHDOG_TIME = (NUM_CYCLES + 20) * CLK_PERIOD;

    logic         clk;
    logic         rst;
    decodeInstr_t decodeIn;
    hazardCtrl_t  ctrl;
    integer       seed;

    // Reference model state
    stageRec_t   mE;
    stageRec_t   mM;
    stageRec_t   mW;
    port2Rec_t   mP2M;
    port2Rec_t   mP2W;
    int          mcCnt;
    logic        mcDoneM;
    regAddr_t    mcDestM;
    hazardCtrl_t expCtrl;

    pipeControl pipeControl_i (
        .clk      (clk),
        .rst      (rst),
        .decodeIn (decodeIn),
        .ctrl     (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("Result: FAILED");
        $fatal(1, "simulation did not finish");
    end

    //////////////////////////////
    // Random stimulus
    //////////////////////////////

    // Mostly r0..r3 so hazards show up often
    function automatic regAddr_t pickReg();
        logic [31:0] r;
        r = $random(seed);
        if (r[2:0] < 3'd6) begin
            return {2'b00, r[4:3]};
        end
        return r[8:5];
    endfunction

    function automatic decodeInstr_t randomInstr();
        decodeInstr_t d;
        logic [31:0]  r;
        d = '0;
        r = $random(seed);
        d.valid = (r[1:0] != 2'b00);
        d.ra1 = pickReg();
        d.ra2 = pickReg();
        d.wa3 = pickReg();
        case (r[5:2])
            4'd0, 4'd1, 4'd2, 4'd3: begin
                d.regWrite = 1'b1;
                d.memtoReg = 1'b1;
            end
            4'd4, 4'd5: d.memWrite = 1'b1;
            4'd6: d.branchTaken = 1'b1;
            // Multi-cycle op writes only through port 2
            4'd7: d.isMcycle = 1'b1;
            4'd8: d.regWrite = 1'b0;
            default: d.regWrite = 1'b1;
        endcase
        return d;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic logic touches(regAddr_t r);
        return decodeIn.ra1 == r || decodeIn.ra2 == r || decodeIn.wa3 == r;
    endfunction

    function automatic fwdSel_t modelFwd(logic srcValid, regAddr_t src);
        if (!srcValid) return FWD_NONE;
        if (mP2M.regWrite2 && mP2M.wa5 == src) return FWD_M2;
        if (mP2W.regWrite2 && mP2W.wa5 == src) return FWD_W2;
        if (mM.valid && mM.regWrite && mM.wa3 == src) return FWD_M;
        if (mW.valid && mW.regWrite && mW.wa3 == src) return FWD_W;
        return FWD_NONE;
    endfunction

    task automatic computeExpected();
        logic ldr;
        logic haz;
        logic startE;
        startE = mE.valid && mE.mStart;
        ldr = decodeIn.valid && mE.valid && mE.regWrite && mE.memtoReg
            && (decodeIn.ra1 == mE.wa3 || decodeIn.ra2 == mE.wa3);
        haz = decodeIn.valid && (((mcCnt != 0) && touches(mcDestM))
            || (startE && touches(mE.wa3))
            || (decodeIn.isMcycle && ((mcCnt != 0) || startE)));
        expCtrl.forwardAE = modelFwd(mE.valid, mE.ra1);
        expCtrl.forwardBE = modelFwd(mE.valid, mE.ra2);
        expCtrl.forwardM = mM.valid && mM.memWrite && mW.valid && mW.regWrite
            && mW.memtoReg && (mM.ra2 == mW.wa3);
        expCtrl.stallF = ldr || mcDoneM || haz;
        expCtrl.stallD = expCtrl.stallF;
        expCtrl.flushD = mE.valid && mE.branchTaken;
        expCtrl.flushE = ldr || expCtrl.flushD;
        expCtrl.mcycleHazard = haz;
    endtask

    // One clock of model state in the order the hardware sees it
    task automatic advanceModel();
        stageRec_t nE;
        logic      doneNext;
        nE = '0;
        if (!expCtrl.stallD && !expCtrl.flushE && decodeIn.valid) begin
            nE.valid       = 1'b1;
            nE.ra1         = decodeIn.ra1;
            nE.ra2         = decodeIn.ra2;
            nE.wa3         = decodeIn.wa3;
            nE.regWrite    = decodeIn.regWrite;
            nE.memWrite    = decodeIn.memWrite;
            nE.memtoReg    = decodeIn.memtoReg;
            nE.branchTaken = decodeIn.branchTaken;
            nE.mStart      = decodeIn.isMcycle;
        end
        mP2W = mP2M;
        mP2M.regWrite2 = mcDoneM;
        mP2M.wa5 = mcDestM;
        doneNext = (mcCnt == 1);
        if (mE.valid && mE.mStart && mcCnt == 0 && !mcDoneM) begin
            mcDestM = mE.wa3;
            mcCnt = MCYCLE_LATENCY;
        end else if (mcCnt != 0) begin
            mcCnt = mcCnt - 1;
        end
        mcDoneM = doneNext;
        mW = mM;
        mM = mE;
        mE = nE;
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic checkFwd(input string name, input fwdSel_t expVal, input fwdSel_t actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expVal, actVal);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic checkBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expVal, actVal);
            $display("Result: FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compareAll();
        checkFwd("forwardAE", expCtrl.forwardAE, ctrl.forwardAE);
        checkFwd("forwardBE", expCtrl.forwardBE, ctrl.forwardBE);
        checkBit("forwardM", expCtrl.forwardM, ctrl.forwardM);
        checkBit("stallF", expCtrl.stallF, ctrl.stallF);
        checkBit("stallD", expCtrl.stallD, ctrl.stallD);
        checkBit("flushD", expCtrl.flushD, ctrl.flushD);
        checkBit("flushE", expCtrl.flushE, ctrl.flushE);
        checkBit("mcycleHazard", expCtrl.mcycleHazard, ctrl.mcycleHazard);
    endtask

    initial begin
        seed = 21463;
        rst = 1'b1;
        decodeIn = '0;
        mE = '0;
        mM = '0;
        mW = '0;
        mP2M = '0;
        mP2W = '0;
        mcCnt = 0;
        mcDoneM = 1'b0;
        mcDestM = '0;
        expCtrl = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            // Stalled descriptor stays on the bus
            if (!expCtrl.stallD) begin
                decodeIn = randomInstr();
            end
            #(CLK_PERIOD / 4);
            computeExpected();
            compareAll();
            advanceModel();
            @(negedge clk);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- pipeControl_assertions.sv
module pipeControlAssertions (
    input logic                   clk,
    input logic                   rst,
    input hazardPkg::hazardCtrl_t ctrl,
    input pipePkg::stageRec_t     stageE,
    input logic                   mcBusy,
    input logic                   mcDone
);

    // Stalled or flushed Decode leaves a bubble in Execute
    bubbleOnHold: assert property (@(posedge clk) disable iff (rst)
        (ctrl.stallD || ctrl.flushE) |=> (stageE == '0))
        else $error("Execute not a bubble after stall or flush");

    // Done is a single cycle pulse
    donePulse: assert property (@(posedge clk) disable iff (rst)
        mcDone |=> !mcDone)
        else $error("mcDone high in two consecutive cycles");

    // No second op reaches Execute while one is in flight
    singleOp: assert property (@(posedge clk) disable iff (rst)
        (mcBusy || mcDone) |-> !stageE.mStart)
        else $error("multi-cycle op in Execute while sequencer busy");

endmodule

bind pipeControl pipeControlAssertions pipeControlAssertions_i (
    .clk    (clk),
    .rst    (rst),
    .ctrl   (ctrl),
    .stageE (stageE),
    .mcBusy (mcBusy),
    .mcDone (mcDone)
);

//--- pipePkg.sv
package pipePkg;

    //////////////////////////////
    // Pipeline constants
    //////////////////////////////

    localparam int REG_ADDR_BITS = 4;

    // Busy cycles after a multi-cycle op leaves Execute
    localparam int MCYCLE_LATENCY = 4;
    localparam int MCYCLE_CNT_BITS = $clog2(MCYCLE_LATENCY + 1);

    typedef logic [REG_ADDR_BITS-1:0] regAddr_t;

    // Descriptor presented at Decode
    typedef struct packed {
        logic     valid;
        regAddr_t ra1;
        regAddr_t ra2;
        regAddr_t wa3;
        logic     regWrite;
        logic     memWrite;
        logic     memtoReg;
        logic     branchTaken;
        logic     isMcycle;
    } decodeInstr_t;

    // Per-stage control record
    // All zeros is a bubble
    typedef struct packed {
        logic     valid;
        regAddr_t ra1;
        regAddr_t ra2;
        regAddr_t wa3;
        logic     regWrite;
        logic     memWrite;
        logic     memtoReg;
        logic     branchTaken;
        logic     mStart;
    } stageRec_t;

    // Second write port slot
    typedef struct packed {
        logic     regWrite2;
        regAddr_t wa5;
    } port2Rec_t;

endpackage

//--- stageTracker.sv
module stageTracker (
    input  logic                  clk,
    input  logic                  rst,
    input  pipePkg::decodeInstr_t decodeIn,
    input  logic                  stallD,
    input  logic                  flushE,
    input  logic                  mcDone,
    input  pipePkg::regAddr_t     mcDest,
    output pipePkg::stageRec_t    stageE,
    output pipePkg::stageRec_t    stageM,
    output pipePkg::stageRec_t    stageW,
    output pipePkg::port2Rec_t    port2M,
    output pipePkg::port2Rec_t    port2W
);
    import pipePkg::*;

    stageRec_t nextE;
    port2Rec_t nextPort2M;

    // Decode descriptor mapped onto an Execute record
    always_comb begin
        nextE = '0;
        if (!stallD && !flushE && decodeIn.valid) begin
            nextE.valid       = 1'b1;
            nextE.ra1         = decodeIn.ra1;
            nextE.ra2         = decodeIn.ra2;
            nextE.wa3         = decodeIn.wa3;
            nextE.regWrite    = decodeIn.regWrite;
            nextE.memWrite    = decodeIn.memWrite;
            nextE.memtoReg    = decodeIn.memtoReg;
            nextE.branchTaken = decodeIn.branchTaken;
            // Multi-cycle flag becomes the sequencer start
            nextE.mStart      = decodeIn.isMcycle;
        end
    end

    always_comb begin
        nextPort2M.regWrite2 = mcDone;
        nextPort2M.wa5       = mcDest;
    end

    //////////////////////////////
    // Normal port stages
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            stageE <= '0;
            stageM <= '0;
            stageW <= '0;
        end else begin
            stageE <= nextE;
            // Memory and Writeback never hold
            stageM <= stageE;
            stageW <= stageM;
        end
    end

    //////////////////////////////
    // Second port slots
    //////////////////////////////

    // Result leaves the sequencer in the done cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            port2M <= '0;
            port2W <= '0;
        end else begin
            port2M <= nextPort2M;
            port2W <= port2M;
        end
    end

endmodule
